// File: project.f
+incdir+.
ram_cmd_pkg.sv
ram_data_pkg.sv
ram_singleport.sv
ram_cmd_decode.sv
ram_read_assemble.sv
ram_scratchpad_top.sv
ram_scratchpad_checker.sv
ram_scratchpad_tb.sv

// File: ram_cmd_decode.sv
// Command decoder of the scratchpad memory.
// Checks each command word and splits it into one request per RAM half.
// Requests are combinational in the command cycle; a rejected command
// gives a one-cycle cmd_err pulse after the sampling edge.

`include "ram_defs.svh"

module ram_cmd_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cmd_valid,
    input  ram_cmd_pkg::cmd_word_t cmd,
    output ram_cmd_pkg::half_req_t lo_req,
    output ram_cmd_pkg::half_req_t hi_req,
    output logic                  rd_issue,
    output logic [3:0]            rd_tag,
    output logic                  cmd_err
);

    logic                       is_read;
    logic                       is_write;
    logic [`CMD_ADDR_WIDTH-1:0] cmd_addr;
    logic                       addr_bad;
    logic                       bad_cmd;
    logic                       wr_ok;
    logic                       rd_ok;
    logic [3:0]                 be;
    logic [4*`LANE_WIDTH-1:0]   wdata;

    assign is_read  = cmd_valid && (cmd.op == ram_cmd_pkg::READ);
    assign is_write = cmd_valid && (cmd.op == ram_cmd_pkg::WRITE);

    // address has the same position in both layouts
    assign cmd_addr = cmd.payload.wr.addr;
    assign addr_bad = (cmd_addr >= `RAM_DEPTH);

    assign bad_cmd = (cmd_valid && (cmd.op == ram_cmd_pkg::RSVD))
                   || ((is_read || is_write) && addr_bad);

    assign wr_ok = is_write && !addr_bad;
    assign rd_ok = is_read && !addr_bad;

    assign be    = wr_ok ? cmd.payload.wr.be : 4'b0000;
    assign wdata = cmd.payload.wr.data;

    // ------------------------------------------------------------------
    // half requests
    // ------------------------------------------------------------------
    always_comb begin
        lo_req.en   = wr_ok || rd_ok;
        lo_req.we   = be[1:0];
        lo_req.addr = cmd_addr[`RAM_ADDR_WIDTH-1:0];
        lo_req.din  = wdata[2*`LANE_WIDTH-1:0];

        hi_req.en   = wr_ok || rd_ok;
        hi_req.we   = be[3:2];
        hi_req.addr = cmd_addr[`RAM_ADDR_WIDTH-1:0];
        hi_req.din  = wdata[4*`LANE_WIDTH-1:2*`LANE_WIDTH];
    end

    assign rd_issue = rd_ok;
    assign rd_tag   = cmd.payload.rd.tag;

    // one-cycle error pulse after the bad command
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_err <= 1'b0;
        end else begin
            cmd_err <= bad_cmd;
        end
    end

endmodule

// File: ram_cmd_pkg.sv
// Request-side types of the scratchpad memory.
// Holds the command word, the two views of its payload and the request
// that the decoder sends to each 16-bit RAM half.

`include "ram_defs.svh"

package ram_cmd_pkg;

    typedef enum logic [1:0] {
        NOP   = 2'd0,
        READ  = 2'd1,
        WRITE = 2'd2,
        RSVD  = 2'd3
    } cmd_op_t;

    // ------------------------------------------------------------------
    // payload layouts, both 46 bits
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [`CMD_ADDR_WIDTH-1:0] addr;
        logic [3:0]                 be;
        logic [4*`LANE_WIDTH-1:0]   data;
    } wr_fields_t;

    typedef struct packed {
        logic [`CMD_ADDR_WIDTH-1:0] addr;
        logic [3:0]                 tag;
        logic [4*`LANE_WIDTH-1:0]   unused;
    } rd_fields_t;

    // one payload word, seen through the layout of its operation
    typedef union packed {
        wr_fields_t wr;
        rd_fields_t rd;
    } cmd_payload_t;

    typedef struct packed {
        cmd_op_t      op;
        cmd_payload_t payload;
    } cmd_word_t;

    // request to one 16-bit RAM half
    typedef struct packed {
        logic                       en;
        logic [1:0]                 we;
        logic [`RAM_ADDR_WIDTH-1:0] addr;
        logic [2*`LANE_WIDTH-1:0]   din;
    } half_req_t;

endpackage

// File: ram_data_pkg.sv
// Response-side types of the scratchpad memory.
// The RAM halves return half_word_t, the assembler joins them into a
// tagged rd_resp_t.

`include "ram_defs.svh"

package ram_data_pkg;

    // data of one 16-bit RAM half
    typedef logic [2*`LANE_WIDTH-1:0] half_word_t;

    // tagged read response, high half in the upper 16 bits
    typedef struct packed {
        logic [3:0]               tag;
        logic [4*`LANE_WIDTH-1:0] data;
    } rd_resp_t;

endpackage

// File: ram_defs.svh
// Sizing and mode macros for the 32-bit scratchpad memory.
// Included by the packages and by every module that needs a size or a
// RAM mode choice.

`ifndef RAM_DEFS_SVH
`define RAM_DEFS_SVH

// RAM word address and depth of each half
`define RAM_ADDR_WIDTH 8
`define RAM_DEPTH 256

// address field in the command word, wider than the RAM
`define CMD_ADDR_WIDTH 10

// bits per byte lane
`define LANE_WIDTH 8

// 1 = write-first, 0 = read-first
`define RAM_WRITE_FIRST 1
`define RAM_DOUT_REGS 1

`endif

// File: ram_read_assemble.sv
// Read response assembler of the scratchpad memory.
// Follows each read through the two RAM register stages with its tag,
// opens the RAM output registers only while a read passes, and joins the
// two halves into one tagged response.

module ram_read_assemble (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    rd_issue,
    input  logic [3:0]              rd_tag,
    input  ram_data_pkg::half_word_t lo_dout,
    input  ram_data_pkg::half_word_t hi_dout,
    output logic                    reg_cke,
    output logic                    rd_valid,
    output ram_data_pkg::rd_resp_t  rd_resp
);

    // stage one matches the RAM read register, stage two the output register
    logic       s1_valid;
    logic [3:0] s1_tag;
    logic       s2_valid;
    logic [3:0] s2_tag;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_tag   <= 4'd0;
            s2_valid <= 1'b0;
            s2_tag   <= 4'd0;
        end else begin
            s1_valid <= rd_issue;
            s1_tag   <= rd_tag;
            s2_valid <= s1_valid;
            s2_tag   <= s1_tag;
        end
    end

    // output registers hold unless a read is in stage one
    assign reg_cke  = s1_valid;

    assign rd_valid      = s2_valid;
    assign rd_resp.tag   = s2_tag;
    assign rd_resp.data  = {hi_dout, lo_dout};

endmodule

// File: ram_scratchpad_checker.sv
// Concurrent assertions on the scratchpad top-level ports.
// Bound into ram_scratchpad_top at the end of this file.

module ram_scratchpad_checker (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   cmd_valid,
    input ram_cmd_pkg::cmd_word_t cmd,
    input logic                   rd_valid,
    input ram_data_pkg::rd_resp_t rd_resp,
    input logic                   cmd_err
);

    // first cycle out of reset
    a_rd_valid_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !rd_valid)
        else $error("rd_valid high in the first cycle after reset");

    // two-cycle read latency
    a_rd_valid_source: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid |-> $past(cmd_valid && cmd.op == ram_cmd_pkg::READ, 2))
        else $error("rd_valid without a read command two edges earlier");

    a_cmd_err_source: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_err |-> $past(cmd_valid))
        else $error("cmd_err without a command one edge earlier");

    a_rd_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(rd_valid) && (rd_valid -> !$isunknown(rd_resp)))
        else $error("rd_valid or read response unknown");

endmodule

bind ram_scratchpad_top ram_scratchpad_checker i_ram_scratchpad_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .rd_valid  (rd_valid),
    .rd_resp   (rd_resp),
    .cmd_err   (cmd_err)
);

// File: ram_scratchpad_tb.sv
// Testbench for the 32-bit scratchpad memory.
// Commands and their expected responses come from ram_vectors.txt. Blank
// lines there separate groups, and a random NOP gap goes between groups.

module ram_scratchpad_tb;

    typedef struct packed {
        logic        gap;
        logic [1:0]  op;
        logic [9:0]  addr;
        logic [3:0]  be_tag;
        logic [31:0] data;
        logic [31:0] exp_data;
        logic        exp_err;
    } vec_t;

    // read in flight with the step at which its response is due
    typedef struct packed {
        int          due;
        logic [3:0]  tag;
        logic [31:0] data;
    } exp_rd_t;

    logic                   clk;
    logic                   rst_n;
    logic                   cmd_valid;
    ram_cmd_pkg::cmd_word_t cmd;
    logic                   rd_valid;
    ram_data_pkg::rd_resp_t rd_resp;
    logic                   cmd_err;

    vec_t    vecs[$];
    exp_rd_t pending[$];
    int      cycle_limit = 1000;
    int      cycles = 0;
    int      step = 0;
    logic    err_due = 1'b0;

    ram_scratchpad_top i_ram_scratchpad_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .rd_valid  (rd_valid),
        .rd_resp   (rd_resp),
        .cmd_err   (cmd_err)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Error at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic read_vectors();
        int          fd;
        int          code;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_addr;
        logic [31:0] f_bt;
        logic [31:0] f_data;
        logic [31:0] f_exp;
        logic [31:0] f_err;
        logic        gap_next;
        vec_t        v;
        fd = $fopen("ram_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file ram_vectors.txt");
            $display("ERRORS FOUND");
            $fatal(1, "no vector file");
        end
        gap_next = 1'b1;
        while ($fgets(line, fd) > 0) begin
            if (line.len() <= 1) begin
                gap_next = 1'b1;
            end else if (line.getc(0) != "#") begin
                code = $sscanf(line, "%h %h %h %h %h %h",
                               f_op, f_addr, f_bt, f_data, f_exp, f_err);
                if (code != 6) begin
                    $display("vector file line has %0d fields instead of 6: %s", code, line);
                    $display("ERRORS FOUND");
                    $fatal(1, "bad vector line");
                end
                v = {gap_next, f_op[1:0], f_addr[9:0], f_bt[3:0], f_data, f_exp, f_err[0]};
                vecs.push_back(v);
                gap_next = 1'b0;
            end
        end
        $fclose(fd);
    endtask

    // payload is laid out through the view that matches the operation
    function automatic ram_cmd_pkg::cmd_word_t build_cmd(input vec_t v);
        ram_cmd_pkg::cmd_word_t w;
        w.op = ram_cmd_pkg::cmd_op_t'(v.op);
        if (v.op == 2'd1) begin
            w.payload.rd.addr   = v.addr;
            w.payload.rd.tag    = v.be_tag;
            w.payload.rd.unused = '0;
        end else begin
            w.payload.wr.addr = v.addr;
            w.payload.wr.be   = v.be_tag;
            w.payload.wr.data = v.data;
        end
        return w;
    endfunction

    // ------------------------------------------------------------------
    // one clock: drive on the rising edge, sample on the falling edge
    // ------------------------------------------------------------------
    task automatic run_cycle(input logic valid, input vec_t v);
        exp_rd_t e;
        @(posedge clk);
        step++;
        cmd_valid <= valid;
        cmd       <= build_cmd(v);
        if (valid && v.op == 2'd1 && !v.exp_err) begin
            // response shows two steps after this drive
            e.due  = step + 2;
            e.tag  = v.be_tag;
            e.data = v.exp_data;
            pending.push_back(e);
        end
        @(negedge clk);
        check_value(64'(cmd_err), 64'(err_due), "cmd_err one cycle after command");
        err_due = valid && v.exp_err;
        if (pending.size() > 0 && pending[0].due == step) begin
            check_value(64'(rd_valid), 64'(1), "rd_valid for a read due this cycle");
        end
        if (rd_valid) begin
            check_value(64'(pending.size() > 0), 64'(1), "rd_valid with no read in flight");
            e = pending.pop_front();
            check_value(64'(step), 64'(e.due), "read latency");
            check_value(64'(rd_resp.tag), 64'(e.tag), "read tag");
            check_value(64'(rd_resp.data), 64'(e.data), "read data");
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            cycles <= cycles + 1;
            if (cycles >= cycle_limit) begin
                $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
                $display("ERRORS FOUND");
                $fatal(1, "timeout");
            end
        end
    end

    initial begin
        int gap_len;
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        void'($urandom(32'hc25c));
        read_vectors();
        cycle_limit = 4 * vecs.size() + 40;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        foreach (vecs[i]) begin
            if (vecs[i].gap) begin
                gap_len = $urandom_range(2, 0);
                repeat (gap_len) run_cycle(1'b0, '0);
            end
            run_cycle(1'b1, vecs[i]);
        end
        // drain reads and error pulses still in flight
        while (pending.size() > 0 || err_due) begin
            run_cycle(1'b0, '0);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: ram_scratchpad_top.sv
// Top level of the 32-bit scratchpad memory.
// Two 16-bit RAM halves run side by side behind one command decoder;
// reads come back two cycles after the command as a tagged response.
// Commands are plain strobes, one per cmd_valid cycle.

`include "ram_defs.svh"

module ram_scratchpad_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cmd_valid,
    input  ram_cmd_pkg::cmd_word_t cmd,
    output logic                   rd_valid,
    output ram_data_pkg::rd_resp_t rd_resp,
    output logic                   cmd_err
);

    ram_cmd_pkg::half_req_t   lo_req;
    ram_cmd_pkg::half_req_t   hi_req;
    logic                     rd_issue;
    logic [3:0]               rd_tag;
    logic                     reg_cke;
    ram_data_pkg::half_word_t lo_dout;
    ram_data_pkg::half_word_t hi_dout;

    ram_cmd_decode i_ram_cmd_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .lo_req    (lo_req),
        .hi_req    (hi_req),
        .rd_issue  (rd_issue),
        .rd_tag    (rd_tag),
        .cmd_err   (cmd_err)
    );

    // ------------------------------------------------------------------
    // RAM halves, bytes 1:0 low and 3:2 high
    // ------------------------------------------------------------------
    ram_singleport #(
        .ADDR_WIDTH  (`RAM_ADDR_WIDTH),
        .WE_WIDTH    (2),
        .WORD_WIDTH  (`LANE_WIDTH),
        .MEM_SIZE    (`RAM_DEPTH),
        .DOUT_REGS   (`RAM_DOUT_REGS),
        .WRITE_FIRST (`RAM_WRITE_FIRST)
    ) i_ram_lo (
        .clk    (clk),
        .en     (lo_req.en),
        .regcke (reg_cke),
        .we     (lo_req.we),
        .addr   (lo_req.addr),
        .din    (lo_req.din),
        .dout   (lo_dout)
    );

    ram_singleport #(
        .ADDR_WIDTH  (`RAM_ADDR_WIDTH),
        .WE_WIDTH    (2),
        .WORD_WIDTH  (`LANE_WIDTH),
        .MEM_SIZE    (`RAM_DEPTH),
        .DOUT_REGS   (`RAM_DOUT_REGS),
        .WRITE_FIRST (`RAM_WRITE_FIRST)
    ) i_ram_hi (
        .clk    (clk),
        .en     (hi_req.en),
        .regcke (reg_cke),
        .we     (hi_req.we),
        .addr   (hi_req.addr),
        .din    (hi_req.din),
        .dout   (hi_dout)
    );

    ram_read_assemble i_ram_read_assemble (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_issue (rd_issue),
        .rd_tag   (rd_tag),
        .lo_dout  (lo_dout),
        .hi_dout  (hi_dout),
        .reg_cke  (reg_cke),
        .rd_valid (rd_valid),
        .rd_resp  (rd_resp)
    );

endmodule

// File: ram_singleport.sv
// Single-port RAM with one write enable per byte lane.
// WRITE_FIRST selects whether a written lane shows the new or the old data
// on the read register. With DOUT_REGS set, a second register follows the
// read register and loads only while regcke is high.

module ram_singleport #(
    parameter int ADDR_WIDTH  = 8,
    parameter int WE_WIDTH    = 2,
    parameter int WORD_WIDTH  = 8,
    parameter int MEM_SIZE    = (1 << ADDR_WIDTH),
    parameter bit DOUT_REGS   = 1,
    parameter bit WRITE_FIRST = 1
) (
    input  logic                           clk,
    input  logic                           en,
    input  logic                           regcke,
    input  logic [WE_WIDTH-1:0]            we,
    input  logic [ADDR_WIDTH-1:0]          addr,
    input  logic [WE_WIDTH*WORD_WIDTH-1:0] din,
    output logic [WE_WIDTH*WORD_WIDTH-1:0] dout
);

    logic [WE_WIDTH*WORD_WIDTH-1:0] mem [0:MEM_SIZE-1];
    logic [WE_WIDTH*WORD_WIDTH-1:0] rd_q;

    // ------------------------------------------------------------------
    // array access and read register
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < WE_WIDTH; i++) begin
                if (we[i]) begin
                    mem[addr][i*WORD_WIDTH +: WORD_WIDTH] <= din[i*WORD_WIDTH +: WORD_WIDTH];
                end
                // written lane bypasses the array in write-first mode
                if (we[i] && WRITE_FIRST) begin
                    rd_q[i*WORD_WIDTH +: WORD_WIDTH] <= din[i*WORD_WIDTH +: WORD_WIDTH];
                end else begin
                    rd_q[i*WORD_WIDTH +: WORD_WIDTH] <= mem[addr][i*WORD_WIDTH +: WORD_WIDTH];
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // optional output register
    // ------------------------------------------------------------------
    if (DOUT_REGS) begin : g_dout_reg
        logic [WE_WIDTH*WORD_WIDTH-1:0] dout_q;

        always_ff @(posedge clk) begin
            if (regcke) begin
                dout_q <= rd_q;
            end
        end

        assign dout = dout_q;
    end else begin : g_dout_direct
        assign dout = rd_q;
    end

endmodule

// File: ram_vectors.txt
# op addr be_or_tag data exp_data exp_err, all hex; op 0 NOP 1 READ 2 WRITE 3 RSVD
# reads carry the tag in column 3; a blank line starts a new group
2 000 f 11223344 00000000 0
2 001 f a5a55a5a 00000000 0
2 0ff f deadbeef 00000000 0
1 000 3 00000000 11223344 0
1 001 7 00000000 a5a55a5a 0
1 0ff c 00000000 deadbeef 0

2 010 f 01020304 00000000 0
2 010 5 aabbccdd 00000000 0
1 010 1 00000000 01bb03dd 0
2 010 a 99887766 00000000 0
1 010 2 00000000 99bb77dd 0
2 011 f ffffffff 00000000 0
2 011 2 12345678 00000000 0
1 011 4 00000000 ffff56ff 0

1 000 8 00000000 11223344 0
1 0ff 9 00000000 deadbeef 0
1 001 a 00000000 a5a55a5a 0
1 010 b 00000000 99bb77dd 0

2 005 f 55aa55aa 00000000 0
2 105 f 0badf00d 00000000 1
1 3ff d 00000000 00000000 1
1 005 c 00000000 55aa55aa 0

3 0ff f ffffffff 00000000 1
0 000 0 00000000 00000000 0
1 0ff 1 00000000 deadbeef 0

2 020 f cafef00d 00000000 0
1 020 6 00000000 cafef00d 0
2 020 c 12340000 00000000 0
1 020 5 00000000 1234f00d 0

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the scratchpad testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module ram_scratchpad_tb \
    -f project.f \
    -o sim_ram_scratchpad

status=0
./obj_dir/sim_ram_scratchpad 2>&1 | tee sim.log || status=$?

if grep -q "ERRORS FOUND" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
